/* logic/periph_pkg.sv */
// peripheral widths and constants for timer and uart
// CLK_MHZ must match the real clock for mtime to count microseconds

package periph_pkg;

	// ----------------------------------------
	// bus and timer
	// ----------------------------------------
	localparam int APB_DATA_W = 32;
	// clocks per microsecond tick
	localparam int CLK_MHZ    = 4;
	localparam int TICK_CTR_W = (CLK_MHZ > 1) ? $clog2(CLK_MHZ) : 1;
	// mtime and mtimecmp, two bus words each
	localparam int MTIME_W    = 64;

	// ----------------------------------------
	// uart
	// ----------------------------------------
	localparam int UART_DIV_W     = 16;
	// clocks per bit out of reset
	localparam int UART_DIV_RESET = 8;
	localparam int UART_DATA_BITS = 8;

	// 8N1 frame sequencing
	typedef enum logic [1:0] {
		UART_IDLE  = 2'd0,
		UART_START = 2'd1,
		UART_DATA  = 2'd2,
		UART_STOP  = 2'd3
	} uart_state_e;

endpackage

/* logic/soc_map_pkg.sv */
// APB fabric address map behind the bridge, 16-bit paddr
// registers are word aligned, offsets decoded from paddr[4:0] only

package soc_map_pkg;

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	localparam int APB_ADDR_W      = 16;
	// timer at 0x0000, uart at 0x4000
	localparam int SLAVE_SEL_BIT   = 14;
	// anything with bit 15 set is unmapped
	localparam int REGION_MASK_BIT = 15;
	localparam int N_SLAVES        = 2;

	typedef enum logic [0:0] {
		SLV_TIMER = 1'b0,
		SLV_UART  = 1'b1
	} slave_idx_e;

	// ----------------------------------------
	// register offsets
	// ----------------------------------------
	typedef enum logic [4:0] {
		TMR_CTRL     = 5'h00,
		TMR_MSIP     = 5'h04,
		TMR_MTIME_LO = 5'h08,
		TMR_MTIME_HI = 5'h0c,
		TMR_CMP_LO   = 5'h10,
		TMR_CMP_HI   = 5'h14
	} timer_reg_e;

	typedef enum logic [4:0] {
		UART_CSR    = 5'h00,
		UART_DIV    = 5'h04,
		UART_TXDATA = 5'h08
	} uart_reg_e;

endpackage

/* logic/apb_splitter.sv */
// one APB master to two slaves, purely combinational
// bit 15 set is unmapped and answered here with pslverr

`timescale 1ns/1ps

module apb_splitter
	import periph_pkg::*;
	import soc_map_pkg::*;
(
	input  logic                           i_psel,
	input  logic                           i_penable,
	input  logic [APB_ADDR_W-1:0]          i_paddr,

	// per-slave responses, packed by slave index
	input  logic [N_SLAVES*APB_DATA_W-1:0] i_slv_prdata,
	input  logic [N_SLAVES-1:0]            i_slv_pready,
	input  logic [N_SLAVES-1:0]            i_slv_pslverr,

	output logic [N_SLAVES-1:0]            o_slv_psel,
	output logic                           o_slv_penable,

	// merged response back to the master
	output logic [APB_DATA_W-1:0]          o_prdata,
	output logic                           o_pready,
	output logic                           o_pslverr
);

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	logic       unmapped;
	slave_idx_e slv_idx;

	assign unmapped = i_paddr[REGION_MASK_BIT];
	assign slv_idx  = slave_idx_e'(i_paddr[SLAVE_SEL_BIT]);

	// only one slave ever sees psel
	always_comb begin
		o_slv_psel = '0;
		if (i_psel && !unmapped) begin
			o_slv_psel[slv_idx] = 1'b1;
		end
	end

	// penable is harmless without psel
	assign o_slv_penable = i_penable;

	// ----------------------------------------
	// response merge
	// ----------------------------------------
	always_comb begin
		if (unmapped) begin
			// complete at once, no data
			o_prdata  = '0;
			o_pready  = 1'b1;
			o_pslverr = i_psel && i_penable;
		end else begin
			o_prdata  = i_slv_prdata[slv_idx*APB_DATA_W +: APB_DATA_W];
			o_pready  = i_slv_pready[slv_idx];
			o_pslverr = i_slv_pslverr[slv_idx];
		end
	end

endmodule

/* logic/mtimer.sv */
// RISC-V style machine timer, mtime counts once per microsecond
// 64-bit registers are written one half at a time, no carry protection

`timescale 1ns/1ps

module mtimer
	import periph_pkg::*;
	import soc_map_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  i_psel,
	input  logic                  i_penable,
	input  logic                  i_pwrite,
	input  logic [APB_ADDR_W-1:0] i_paddr,
	input  logic [APB_DATA_W-1:0] i_pwdata,
	output logic [APB_DATA_W-1:0] o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,

	// pause counting while the core is halted
	input  logic                  i_dbg_halt,

	output logic                  o_soft_irq,
	output logic                  o_timer_irq
);

	logic [TICK_CTR_W-1:0] tick_ctr;
	logic                  tick;
	logic                  ctrl_en;
	logic                  msip;
	logic [MTIME_W-1:0]    mtime;
	logic [MTIME_W-1:0]    mtimecmp;
	logic                  wr_en;
	logic                  count_en;
	timer_reg_e            tmr_off;

	// every access finishes in its first access cycle
	assign o_pready  = 1'b1;
	assign o_pslverr = 1'b0;

	assign tmr_off = timer_reg_e'(i_paddr[4:0]);
	assign wr_en   = i_psel && i_penable && i_pwrite;

	// ----------------------------------------
	// microsecond prescaler
	// ----------------------------------------
	// free running, counts down to zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= TICK_CTR_W'(CLK_MHZ - 1);
		end else if (tick) begin
			tick_ctr <= TICK_CTR_W'(CLK_MHZ - 1);
		end else begin
			tick_ctr <= tick_ctr - 1'b1;
		end
	end

	assign tick     = (tick_ctr == '0);
	assign count_en = tick && ctrl_en && !i_dbg_halt;

	// ----------------------------------------
	// control registers
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b0;
			msip    <= 1'b0;
		end else if (wr_en) begin
			if (tmr_off == TMR_CTRL)
				ctrl_en <= i_pwdata[0];
			if (tmr_off == TMR_MSIP)
				msip <= i_pwdata[0];
		end
	end

	assign o_soft_irq = msip;

	// bus write wins over the tick
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_en && tmr_off == TMR_MTIME_LO) begin
			mtime[APB_DATA_W-1:0] <= i_pwdata;
		end else if (wr_en && tmr_off == TMR_MTIME_HI) begin
			mtime[MTIME_W-1:APB_DATA_W] <= i_pwdata;
		end else if (count_en) begin
			mtime <= mtime + 1'b1;
		end
	end

	// all ones keeps the irq quiet out of reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else if (wr_en && tmr_off == TMR_CMP_LO) begin
			mtimecmp[APB_DATA_W-1:0] <= i_pwdata;
		end else if (wr_en && tmr_off == TMR_CMP_HI) begin
			mtimecmp[MTIME_W-1:APB_DATA_W] <= i_pwdata;
		end
	end

	// compare is registered, one clock behind mtime
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_timer_irq <= 1'b0;
		else
			o_timer_irq <= (mtime >= mtimecmp);
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	always_comb begin
		case (tmr_off)
			TMR_CTRL:     o_prdata = {{(APB_DATA_W-1){1'b0}}, ctrl_en};
			TMR_MSIP:     o_prdata = {{(APB_DATA_W-1){1'b0}}, msip};
			TMR_MTIME_LO: o_prdata = mtime[APB_DATA_W-1:0];
			TMR_MTIME_HI: o_prdata = mtime[MTIME_W-1:APB_DATA_W];
			TMR_CMP_LO:   o_prdata = mtimecmp[APB_DATA_W-1:0];
			TMR_CMP_HI:   o_prdata = mtimecmp[MTIME_W-1:APB_DATA_W];
			// holes read as zero
			default:      o_prdata = '0;
		endcase
	end

endmodule

/* logic/uart_tx.sv */
// 8N1 transmitter, DIV clocks per bit, DIV must be nonzero
// a TXDATA write while busy stalls pready until the stop bit ends

`timescale 1ns/1ps

module uart_tx
	import periph_pkg::*;
	import soc_map_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  i_psel,
	input  logic                  i_penable,
	input  logic                  i_pwrite,
	input  logic [APB_ADDR_W-1:0] i_paddr,
	input  logic [APB_DATA_W-1:0] i_pwdata,
	output logic [APB_DATA_W-1:0] o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,

	output logic                  o_uart_tx
);

	localparam int BIT_CTR_W = $clog2(UART_DATA_BITS);

	uart_state_e               state;
	uart_reg_e                 uart_off;
	logic [UART_DIV_W-1:0]     div_q;
	logic [UART_DIV_W-1:0]     baud_ctr;
	logic [UART_DATA_BITS-1:0] shift_q;
	logic [BIT_CTR_W-1:0]      bit_ctr;
	logic                      busy;
	logic                      bit_end;
	logic                      frame_end;
	logic                      wr_tx;
	logic                      tx_go;

	assign uart_off  = uart_reg_e'(i_paddr[4:0]);
	assign busy      = (state != UART_IDLE);
	assign bit_end   = (baud_ctr == '0);
	// last clock of the stop bit
	assign frame_end = (state == UART_STOP) && bit_end;

	// ----------------------------------------
	// bus side
	// ----------------------------------------
	assign wr_tx     = i_psel && i_penable && i_pwrite && (uart_off == UART_TXDATA);
	// accepted when idle or as the current frame finishes
	assign tx_go     = wr_tx && (!busy || frame_end);
	assign o_pready  = !(wr_tx && busy && !frame_end);
	assign o_pslverr = 1'b0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			div_q <= UART_DIV_W'(UART_DIV_RESET);
		else if (i_psel && i_penable && i_pwrite && uart_off == UART_DIV)
			div_q <= i_pwdata[UART_DIV_W-1:0];
	end

	// txdata is write only
	always_comb begin
		case (uart_off)
			UART_CSR: o_prdata = {{(APB_DATA_W-1){1'b0}}, busy};
			UART_DIV: o_prdata = {{(APB_DATA_W-UART_DIV_W){1'b0}}, div_q};
			default:  o_prdata = '0;
		endcase
	end

	// ----------------------------------------
	// frame FSM
	// ----------------------------------------
	// byte register carries no reset
	always_ff @(posedge clk) begin
		if (tx_go)
			shift_q <= i_pwdata[UART_DATA_BITS-1:0];
		else if (bit_end && (state == UART_START || state == UART_DATA))
			shift_q <= shift_q >> 1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= UART_IDLE;
			baud_ctr  <= '0;
			bit_ctr   <= '0;
			o_uart_tx <= 1'b1;
		end else begin
			// each bit lasts div_q clocks, counted down to zero
			if (!bit_end)
				baud_ctr <= baud_ctr - 1'b1;
			case (state)
				UART_IDLE: begin
					if (tx_go) begin
						state     <= UART_START;
						baud_ctr  <= div_q - 1'b1;
						o_uart_tx <= 1'b0;
					end
				end
				UART_START: begin
					if (bit_end) begin
						state     <= UART_DATA;
						baud_ctr  <= div_q - 1'b1;
						bit_ctr   <= '0;
						o_uart_tx <= shift_q[0];
					end
				end
				UART_DATA: begin
					if (bit_end) begin
						baud_ctr <= div_q - 1'b1;
						if (bit_ctr == BIT_CTR_W'(UART_DATA_BITS - 1)) begin
							state     <= UART_STOP;
							o_uart_tx <= 1'b1;
						end else begin
							bit_ctr   <= bit_ctr + 1'b1;
							o_uart_tx <= shift_q[0];
						end
					end
				end
				UART_STOP: begin
					// stalled write goes straight into a new start bit
					if (bit_end) begin
						if (tx_go) begin
							state     <= UART_START;
							baud_ctr  <= div_q - 1'b1;
							o_uart_tx <= 1'b0;
						end else begin
							state <= UART_IDLE;
						end
					end
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

endmodule

/* logic/apb_periph_top.sv */
// APB peripheral block, splitter plus machine timer and uart tx
// latency is that of the addressed slave, splitter adds none

`timescale 1ns/1ps

module apb_periph_top
	import periph_pkg::*;
	import soc_map_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  i_psel,
	input  logic                  i_penable,
	input  logic                  i_pwrite,
	input  logic [APB_ADDR_W-1:0] i_paddr,
	input  logic [APB_DATA_W-1:0] i_pwdata,
	output logic [APB_DATA_W-1:0] o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,

	input  logic                  i_dbg_halt,

	output logic                  o_timer_irq,
	output logic                  o_soft_irq,
	output logic                  o_uart_tx
);

	// ----------------------------------------
	// fabric
	// ----------------------------------------
	logic [N_SLAVES-1:0]            slv_psel;
	logic                           slv_penable;
	logic [N_SLAVES*APB_DATA_W-1:0] slv_prdata;
	logic [N_SLAVES-1:0]            slv_pready;
	logic [N_SLAVES-1:0]            slv_pslverr;

	apb_splitter u_split (
		.i_psel        (i_psel),
		.i_penable     (i_penable),
		.i_paddr       (i_paddr),
		.i_slv_prdata  (slv_prdata),
		.i_slv_pready  (slv_pready),
		.i_slv_pslverr (slv_pslverr),
		.o_slv_psel    (slv_psel),
		.o_slv_penable (slv_penable),
		.o_prdata      (o_prdata),
		.o_pready      (o_pready),
		.o_pslverr     (o_pslverr)
	);

	// ----------------------------------------
	// slaves
	// ----------------------------------------
	// paddr, pwrite and pwdata go to both
	mtimer u_timer (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_psel      (slv_psel[SLV_TIMER]),
		.i_penable   (slv_penable),
		.i_pwrite    (i_pwrite),
		.i_paddr     (i_paddr),
		.i_pwdata    (i_pwdata),
		.o_prdata    (slv_prdata[SLV_TIMER*APB_DATA_W +: APB_DATA_W]),
		.o_pready    (slv_pready[SLV_TIMER]),
		.o_pslverr   (slv_pslverr[SLV_TIMER]),
		.i_dbg_halt  (i_dbg_halt),
		.o_soft_irq  (o_soft_irq),
		.o_timer_irq (o_timer_irq)
	);

	uart_tx u_uart (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_psel    (slv_psel[SLV_UART]),
		.i_penable (slv_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (slv_prdata[SLV_UART*APB_DATA_W +: APB_DATA_W]),
		.o_pready  (slv_pready[SLV_UART]),
		.o_pslverr (slv_pslverr[SLV_UART]),
		.o_uart_tx (o_uart_tx)
	);

endmodule

/* verif/tb_apb_periph.sv */
// testbench for the APB peripheral block, one master driving timer and uart
// frame checks assume DIV is reprogrammed to 4 before any byte goes out

`timescale 1ns/1ps

module tb_apb_periph
	import periph_pkg::*;
	import soc_map_pkg::*;
();

	localparam int CLK_PERIOD  = 4;
	localparam int TEST_DIV    = 4;
	// reset, timer tests, then 20 frames at the reset divisor
	localparam int TEST_CYCLES = 16 + 600 + 20 * 10 * UART_DIV_RESET;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_PERIOD + 2000;
	localparam logic [APB_ADDR_W-1:0] UART_BASE = APB_ADDR_W'(1 << SLAVE_SEL_BIT);
	localparam logic [APB_ADDR_W-1:0] HOLE_BASE = APB_ADDR_W'(1 << REGION_MASK_BIT);

	logic                  clk;
	logic                  rst_n;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic [APB_DATA_W-1:0] prdata;
	logic                  pready;
	logic                  pslverr;
	logic                  dbg_halt;
	logic                  timer_irq;
	logic                  soft_irq;
	logic                  uart_tx;

	int          cyc = 0;
	int          test_errs = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          irq_errs = 0;
	string       cur_test = "none";
	integer      seed = 32'h1b461408;
	// results of the last bus transfer
	logic        xfer_err;
	int          xfer_cyc;
	int          xfer_waits;
	logic        cmp_hit;

	apb_periph_top dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_psel      (psel),
		.i_penable   (penable),
		.i_pwrite    (pwrite),
		.i_paddr     (paddr),
		.i_pwdata    (pwdata),
		.o_prdata    (prdata),
		.o_pready    (pready),
		.o_pslverr   (pslverr),
		.i_dbg_halt  (dbg_halt),
		.o_timer_irq (timer_irq),
		.o_soft_irq  (soft_irq),
		.o_uart_tx   (uart_tx)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// free cycle count, read only at falling edges
	always @(posedge clk) cyc <= cyc + 1;

	// ----------------------------------------
	// irq rule
	// ----------------------------------------
	assign cmp_hit = (dut.u_timer.mtime >= dut.u_timer.mtimecmp);

	// irq is registered, so a rise needs the compare true one clock before
	assert property (@(negedge clk) disable iff (!rst_n) $rose(timer_irq) |-> $past(cmp_hit))
	else begin
		irq_errs = irq_errs + 1;
		$display("timer irq rose while mtime was below mtimecmp during %s", cur_test);
	end

	// ----------------------------------------
	// checks and bookkeeping
	// ----------------------------------------
	task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp)
		else begin
			test_errs = test_errs + 1;
			$display("FAIL %s %s expected %h actual %h", cur_test, what, exp, act);
		end
	endtask

	// tolerance of one tick for prescaler phase
	task automatic check_near(input string what, input int exp, input int act);
		assert (act >= exp - 1 && act <= exp + 1)
		else begin
			test_errs = test_errs + 1;
			$display("FAIL %s %s expected %0d actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond === 1'b1)
		else begin
			test_errs = test_errs + 1;
			$display("%s: %s", cur_test, msg);
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		if (test_errs == 0) begin
			pass_cnt = pass_cnt + 1;
			$display("test %s ok", cur_test);
		end else begin
			fail_cnt = fail_cnt + 1;
			$display("test %s had %0d errors", cur_test, test_errs);
		end
	endtask

	function automatic logic [APB_ADDR_W-1:0] tmr_addr(input timer_reg_e off);
		return APB_ADDR_W'(off);
	endfunction

	function automatic logic [APB_ADDR_W-1:0] uart_addr(input uart_reg_e off);
		return UART_BASE | APB_ADDR_W'(off);
	endfunction

	// ----------------------------------------
	// APB master
	// ----------------------------------------
	// setup, then access until pready, sampled at the falling edge
	task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		xfer_waits = 0;
		@(negedge clk);
		while (pready !== 1'b1) begin
			xfer_waits = xfer_waits + 1;
			@(negedge clk);
		end
		rdata    = prdata;
		xfer_err = pslverr;
		xfer_cyc = cyc;
		// transfer completes on this edge
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_xfer(1'b1, addr, data, unused);
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
		apb_xfer(1'b0, addr, 32'd0, data);
	endtask

	// ----------------------------------------
	// serial receiver
	// ----------------------------------------
	// 8N1, sampled near the middle of each bit
	task automatic capture_frame(input int div, output logic [7:0] data);
		@(negedge clk);
		while (uart_tx !== 1'b0) @(negedge clk);
		// first low sample is half a clock into the start bit
		repeat (div / 2 - 1) @(negedge clk);
		check_eq("start bit", 32'd0, 32'(uart_tx));
		for (int i = 0; i < UART_DATA_BITS; i++) begin
			repeat (div) @(negedge clk);
			data[i] = uart_tx;
		end
		repeat (div) @(negedge clk);
		check_eq("stop bit", 32'd1, 32'(uart_tx));
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		logic [31:0] rd;
		logic [31:0] val;
		logic [31:0] mt0;
		logic [31:0] mt1;
		logic [31:0] cmp_hi;
		logic [7:0]  tx_a;
		logic [7:0]  tx_b;
		logic [7:0]  rx_a;
		logic [7:0]  rx_b;
		int          c0;
		int          c1;
		int          polls;

		rst_n    <= 1'b0;
		psel     <= 1'b0;
		penable  <= 1'b0;
		pwrite   <= 1'b0;
		paddr    <= '0;
		pwdata   <= '0;
		dbg_halt <= 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// reset values, then random write and read back
		start_test("reset_readback");
		@(negedge clk);
		check_eq("uart_tx idle", 32'd1, 32'(uart_tx));
		check_eq("timer_irq", 32'd0, 32'(timer_irq));
		check_eq("soft_irq", 32'd0, 32'(soft_irq));
		apb_read(uart_addr(UART_DIV), rd);
		check_eq("div reset", 32'(UART_DIV_RESET), rd);
		apb_read(tmr_addr(TMR_MTIME_LO), rd);
		check_eq("mtime lo", 32'd0, rd);
		apb_read(tmr_addr(TMR_CMP_HI), rd);
		check_eq("mtimecmp hi", 32'hffff_ffff, rd);
		val = $random(seed);
		apb_write(tmr_addr(TMR_CMP_LO), val);
		apb_read(tmr_addr(TMR_CMP_LO), rd);
		check_eq("mtimecmp lo", val, rd);
		val = $random(seed);
		apb_write(tmr_addr(TMR_CMP_HI), val);
		apb_read(tmr_addr(TMR_CMP_HI), rd);
		check_eq("mtimecmp hi", val, rd);
		// only 16 divisor bits exist
		val = $random(seed);
		apb_write(uart_addr(UART_DIV), val);
		apb_read(uart_addr(UART_DIV), rd);
		check_eq("div", val & 32'h0000_ffff, rd);
		finish_test();

		// one tick per CLK_MHZ clocks, frozen by debug halt
		start_test("timebase");
		apb_write(tmr_addr(TMR_CTRL), 32'd1);
		apb_read(tmr_addr(TMR_MTIME_LO), mt0);
		c0 = xfer_cyc;
		repeat (40) @(posedge clk);
		apb_read(tmr_addr(TMR_MTIME_LO), mt1);
		c1 = xfer_cyc;
		check_near("ticks", (c1 - c0) / CLK_MHZ, int'(mt1 - mt0));
		@(posedge clk);
		dbg_halt <= 1'b1;
		apb_read(tmr_addr(TMR_MTIME_LO), mt0);
		repeat (40) @(posedge clk);
		apb_read(tmr_addr(TMR_MTIME_LO), mt1);
		check_eq("mtime while halted", mt0, mt1);
		@(posedge clk);
		dbg_halt <= 1'b0;
		finish_test();

		start_test("interrupts");
		apb_write(tmr_addr(TMR_MSIP), 32'd1);
		@(negedge clk);
		check_eq("soft_irq set", 32'd1, 32'(soft_irq));
		apb_write(tmr_addr(TMR_MSIP), 32'd0);
		@(negedge clk);
		check_eq("soft_irq clear", 32'd0, 32'(soft_irq));
		// park compare high before bringing it close
		apb_write(tmr_addr(TMR_CMP_LO), 32'hffff_ffff);
		apb_write(tmr_addr(TMR_CMP_HI), 32'd0);
		apb_read(tmr_addr(TMR_MTIME_LO), mt0);
		val = mt0 + 32'd5;
		apb_write(tmr_addr(TMR_CMP_LO), val);
		polls = 0;
		mt1   = mt0;
		while (mt1 < val && polls < 64) begin
			apb_read(tmr_addr(TMR_MTIME_LO), mt1);
			polls = polls + 1;
			if (mt1 < val) begin
				@(negedge clk);
				check_eq("timer_irq before compare", 32'd0, 32'(timer_irq));
			end
		end
		check_true(mt1 >= val, "mtime never reached the compare value");
		// at most two clocks after the read
		@(negedge clk);
		polls = 0;
		while (timer_irq !== 1'b1 && polls < 1) begin
			@(negedge clk);
			polls = polls + 1;
		end
		check_eq("timer_irq after compare", 32'd1, 32'(timer_irq));
		finish_test();

		start_test("serial_frame");
		apb_write(uart_addr(UART_DIV), 32'(TEST_DIV));
		tx_a = 8'($random(seed));
		fork
			capture_frame(TEST_DIV, rx_a);
			begin
				apb_write(uart_addr(UART_TXDATA), 32'(tx_a));
				apb_read(uart_addr(UART_CSR), rd);
				check_eq("busy during frame", 32'd1, rd);
			end
		join
		check_eq("frame byte", 32'(tx_a), 32'(rx_a));
		// stop bit still running when the receiver returns
		repeat (TEST_DIV) @(posedge clk);
		apb_read(uart_addr(UART_CSR), rd);
		check_eq("busy after frame", 32'd0, rd);
		finish_test();

		// second write held until the first stop bit ends
		start_test("back_pressure");
		tx_a = 8'($random(seed));
		tx_b = 8'($random(seed));
		fork
			begin
				capture_frame(TEST_DIV, rx_a);
				capture_frame(TEST_DIV, rx_b);
			end
			begin
				apb_write(uart_addr(UART_TXDATA), 32'(tx_a));
				c0 = xfer_cyc;
				apb_write(uart_addr(UART_TXDATA), 32'(tx_b));
				c1 = xfer_cyc;
				check_true(xfer_waits > 0, "second TXDATA write was not stalled");
				check_eq("release cycle", 32'(10 * TEST_DIV), 32'(c1 - c0));
			end
		join
		check_eq("first byte", 32'(tx_a), 32'(rx_a));
		check_eq("second byte", 32'(tx_b), 32'(rx_b));
		finish_test();

		start_test("unmapped");
		apb_read(tmr_addr(TMR_CMP_HI), cmp_hi);
		// aliases of real registers with bit 15 set
		apb_write(HOLE_BASE | uart_addr(UART_DIV), $random(seed));
		check_eq("write pslverr", 32'd1, 32'(xfer_err));
		apb_write(HOLE_BASE | tmr_addr(TMR_MSIP), 32'd1);
		check_eq("msip pslverr", 32'd1, 32'(xfer_err));
		apb_write(HOLE_BASE | tmr_addr(TMR_CMP_HI), ~cmp_hi);
		check_eq("cmp pslverr", 32'd1, 32'(xfer_err));
		apb_read(HOLE_BASE | tmr_addr(TMR_CMP_HI), rd);
		check_eq("read pslverr", 32'd1, 32'(xfer_err));
		check_eq("read data", 32'd0, rd);
		@(negedge clk);
		check_eq("soft_irq", 32'd0, 32'(soft_irq));
		apb_read(uart_addr(UART_DIV), rd);
		check_eq("div kept", 32'(TEST_DIV), rd);
		apb_read(tmr_addr(TMR_CMP_HI), rd);
		check_eq("mtimecmp hi kept", cmp_hi, rd);
		finish_test();

		$display("tests passed %0d failed %0d irq rule errors %0d", pass_cnt, fail_cnt, irq_errs);
		if (fail_cnt == 0 && irq_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* build.f */
logic/periph_pkg.sv
logic/soc_map_pkg.sv
logic/apb_splitter.sv
logic/mtimer.sv
logic/uart_tx.sv
logic/apb_periph_top.sv
verif/tb_apb_periph.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the APB peripheral testbench with Verilator, verdict from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_apb_periph \
	-Mdir obj_dir > sim.log 2>&1 \
	&& ./obj_dir/Vtb_apb_periph >> sim.log 2>&1 \
	|| echo "compile or run step returned an error" >> sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"
exit 0
